/* Makefile */
TOP = proto_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f vlog.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f vlog.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

/* hdl/mailbox_ram.sv */
// Dual-port mailbox shared by the processor and the protocol controller
`timescale 1ns/1ps
`default_nettype none

module mailbox_ram (
	input wire clk,
	input wire proto_pkg::mbox_req_t a_req_i,
	output logic [proto_pkg::MBOX_DW-1:0] a_rdata_o,
	input wire proto_pkg::mbox_req_t b_req_i,
	output logic [proto_pkg::MBOX_DW-1:0] b_rdata_o
);

	logic [proto_pkg::MBOX_DW-1:0] mem [2**proto_pkg::MBOX_AW];
	logic same_word;

	// Mailbox comes up cleared
	initial begin
		for (int w = 0; w < 2**proto_pkg::MBOX_AW; w++) begin
			mem[w] = '0;
		end
	end

	assign same_word = (a_req_i.addr == b_req_i.addr);

	always @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			// Processor port owns a byte that both ports hit
			if (a_req_i.be[i]) begin
				mem[a_req_i.addr][8*i +: 8] <= a_req_i.wdata[8*i +: 8];
			end
			if (b_req_i.be[i] && !(same_word && a_req_i.be[i])) begin
				mem[b_req_i.addr][8*i +: 8] <= b_req_i.wdata[8*i +: 8];
			end
		end
		// Read old contents, one cycle latency
		a_rdata_o <= mem[a_req_i.addr];
		b_rdata_o <= mem[b_req_i.addr];
	end

endmodule

`default_nettype wire

/* hdl/proto_ctrl.sv */
// Mailbox command sequencer for SPI and UART transfers with interrupt
`timescale 1ns/1ps
`default_nettype none

module proto_ctrl (
	input wire clk,
	input wire arst_n_i,
	output proto_pkg::mbox_req_t mb_req_o,
	input wire [proto_pkg::MBOX_DW-1:0] mb_rdata_i,
	output logic spi_start_o,
	output logic [7:0] spi_byte_o,
	output logic [1:0] spi_ss_o,
	output logic spi_hold_o,
	input wire spi_done_i,
	input wire [7:0] spi_byte_i,
	output logic utx_start_o,
	output logic [7:0] utx_byte_o,
	input wire utx_done_i,
	input wire urx_valid_i,
	input wire [7:0] urx_byte_i,
	output logic urx_take_o,
	input wire urx_ovr_i,
	output logic int_o
);

	proto_pkg::ctrl_state_e state_q, state_d;
	proto_pkg::cmd_t cmd_d, cmd_q;
	logic err_d, err_q;
	logic [3:0] idx_q;
	logic [7:0] cnt_q, urx_cnt_q;
	logic [7:0] tx_byte;
	logic [proto_pkg::MBOX_AW-1:0] word_ofs;
	logic is_spi, xfer_done, last_byte;

	// Command fields from the word read last cycle
	assign cmd_d.op = proto_pkg::opcode_e'(mb_rdata_i[proto_pkg::CMD_OP_LSB +: 4]);
	assign cmd_d.ss = mb_rdata_i[proto_pkg::CMD_SS_LSB +: 2];
	assign cmd_d.len = mb_rdata_i[proto_pkg::CMD_LEN_LSB +: 4];
	assign cmd_d.go = mb_rdata_i[proto_pkg::CMD_GO_BIT];

	// Unknown opcode, or transfer length outside 1..8
	always_comb begin
		case (cmd_d.op)
			proto_pkg::OP_NOP: err_d = 1'b0;
			proto_pkg::OP_SPI_XFER, proto_pkg::OP_UART_SEND:
				err_d = (cmd_d.len == 4'd0) || (cmd_d.len > proto_pkg::MAX_LEN);
			default: err_d = 1'b1;
		endcase
	end

	assign is_spi = (cmd_q.op == proto_pkg::OP_SPI_XFER);
	assign xfer_done = is_spi ? spi_done_i : utx_done_i;
	assign last_byte = ((idx_q + 4'd1) == cmd_q.len);
	// Bytes 0..3 in the first word, 4..7 in the second
	assign word_ofs = {{(proto_pkg::MBOX_AW-1){1'b0}}, idx_q[2]};
	assign tx_byte = mb_rdata_i[{idx_q[1:0], 3'b000} +: 8];

	assign spi_byte_o = tx_byte;
	assign utx_byte_o = tx_byte;
	assign spi_ss_o = cmd_q.ss;
	// go doubles as the transfer-active flag once latched
	assign spi_hold_o = cmd_q.go && is_spi;
	assign int_o = (state_q == proto_pkg::ST_DONE);

	always_comb begin
		state_d = state_q;
		mb_req_o.addr = proto_pkg::ADDR_CMD;
		mb_req_o.be = 4'b0000;
		mb_req_o.wdata = '0;
		spi_start_o = 1'b0;
		utx_start_o = 1'b0;
		urx_take_o = 1'b0;
		case (state_q)
			proto_pkg::ST_IDLE: begin
				if (urx_valid_i) begin
					// Byte plus running count
					mb_req_o.addr = proto_pkg::ADDR_URX;
					mb_req_o.be = 4'b0011;
					mb_req_o.wdata[7:0] = urx_byte_i;
					mb_req_o.wdata[proto_pkg::URX_CNT_LSB +: 8] = urx_cnt_q + 8'd1;
					urx_take_o = 1'b1;
					state_d = proto_pkg::ST_DONE;
				end else begin
					// Poll read of the command word
					state_d = proto_pkg::ST_CMD;
				end
			end
			proto_pkg::ST_CMD: begin
				if (cmd_d.go) begin
					// Clear go, top byte only
					mb_req_o.be = 4'b1000;
					mb_req_o.wdata = mb_rdata_i;
					mb_req_o.wdata[proto_pkg::CMD_GO_BIT] = 1'b0;
					if (err_d || cmd_d.op == proto_pkg::OP_NOP) begin
						state_d = proto_pkg::ST_STAT;
					end else begin
						state_d = proto_pkg::ST_FETCH;
					end
				end else begin
					state_d = proto_pkg::ST_IDLE;
				end
			end
			proto_pkg::ST_FETCH: begin
				mb_req_o.addr = proto_pkg::ADDR_TX0 + word_ofs;
				state_d = proto_pkg::ST_SEND;
			end
			proto_pkg::ST_SEND: begin
				spi_start_o = is_spi;
				utx_start_o = !is_spi;
				state_d = proto_pkg::ST_WAIT;
			end
			proto_pkg::ST_WAIT: begin
				if (xfer_done) begin
					if (is_spi) begin
						// Drop the received byte into its lane
						mb_req_o.addr = proto_pkg::ADDR_RX0 + word_ofs;
						mb_req_o.be = 4'b0001 << idx_q[1:0];
						mb_req_o.wdata = {4{spi_byte_i}};
					end
					state_d = last_byte ? proto_pkg::ST_STAT : proto_pkg::ST_FETCH;
				end
			end
			proto_pkg::ST_STAT: begin
				mb_req_o.addr = proto_pkg::ADDR_STAT;
				mb_req_o.be = 4'b1111;
				mb_req_o.wdata[7:0] = cnt_q + 8'd1;
				mb_req_o.wdata[proto_pkg::STAT_OP_LSB +: 4] = cmd_q.op;
				mb_req_o.wdata[proto_pkg::STAT_ERR_BIT] = err_q;
				mb_req_o.wdata[proto_pkg::STAT_OVR_BIT] = urx_ovr_i;
				state_d = proto_pkg::ST_DONE;
			end
			default: state_d = proto_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= proto_pkg::ST_IDLE;
			cmd_q <= '0;
			err_q <= 1'b0;
			idx_q <= 4'd0;
			cnt_q <= 8'd0;
			urx_cnt_q <= 8'd0;
		end else begin
			state_q <= state_d;
			if (urx_take_o) begin
				urx_cnt_q <= urx_cnt_q + 8'd1;
			end
			if (state_q == proto_pkg::ST_CMD && cmd_d.go) begin
				cmd_q <= cmd_d;
				// Only a valid transfer runs
				cmd_q.go <= !err_d && (cmd_d.op != proto_pkg::OP_NOP);
				err_q <= err_d;
				idx_q <= 4'd0;
			end
			if (state_q == proto_pkg::ST_WAIT && xfer_done) begin
				idx_q <= idx_q + 4'd1;
				if (last_byte) begin
					cmd_q.go <= 1'b0;
				end
			end
			if (state_q == proto_pkg::ST_STAT) begin
				cnt_q <= cnt_q + 8'd1;
			end
		end
	end

	// Commands and UART bytes each end in a separate single-cycle pulse
	a_int_single: assert property (@(posedge clk) disable iff (!arst_n_i)
		int_o |=> !int_o);

endmodule

`default_nettype wire

/* hdl/proto_pkg.sv */
// Protocol controller package with mailbox map, serial timing and shared types
`default_nettype none

package proto_pkg;

	// Mailbox geometry
	localparam int MBOX_AW = 4;
	localparam int MBOX_DW = 32;

	// Word addresses
	localparam logic [MBOX_AW-1:0] ADDR_CMD = 4'd0;
	localparam logic [MBOX_AW-1:0] ADDR_TX0 = 4'd1;
	localparam logic [MBOX_AW-1:0] ADDR_TX1 = 4'd2;
	localparam logic [MBOX_AW-1:0] ADDR_RX0 = 4'd3;
	localparam logic [MBOX_AW-1:0] ADDR_RX1 = 4'd4;
	localparam logic [MBOX_AW-1:0] ADDR_STAT = 4'd5;
	localparam logic [MBOX_AW-1:0] ADDR_URX = 4'd6;

	// Command word layout
	localparam int CMD_OP_LSB = 0;
	localparam int CMD_SS_LSB = 4;
	localparam int CMD_LEN_LSB = 8;
	localparam int CMD_GO_BIT = 31;
	localparam logic [3:0] MAX_LEN = 4'd8;

	// Status and UART receive word layout
	localparam int STAT_OP_LSB = 8;
	localparam int STAT_ERR_BIT = 16;
	localparam int STAT_OVR_BIT = 17;
	localparam int URX_CNT_LSB = 8;

	// SCK half period, in system clocks
	localparam int SPI_DIV = 4;
	localparam int SPI_CW = $clog2(SPI_DIV);
	localparam logic [SPI_CW-1:0] SPI_LAST = SPI_CW'(SPI_DIV - 1);

	// UART bit period, in system clocks
	localparam int BAUD_DIV = 16;
	localparam int BAUD_CW = $clog2(BAUD_DIV);
	localparam logic [BAUD_CW-1:0] BAUD_LAST = BAUD_CW'(BAUD_DIV - 1);
	localparam logic [BAUD_CW-1:0] BAUD_HALF = BAUD_CW'(BAUD_DIV / 2);

	typedef enum logic [3:0] {
		OP_NOP = 4'h0,
		OP_SPI_XFER = 4'h1,
		OP_UART_SEND = 4'h2
	} opcode_e;

	typedef enum logic [2:0] {
		ST_IDLE, ST_CMD, ST_FETCH, ST_SEND, ST_WAIT, ST_STAT, ST_DONE
	} ctrl_state_e;

	// One mailbox port request, a write when any be bit is set
	typedef struct packed {
		logic [MBOX_AW-1:0] addr;
		logic [3:0] be;
		logic [MBOX_DW-1:0] wdata;
	} mbox_req_t;

	typedef struct packed {
		opcode_e op;
		logic [1:0] ss;
		logic [3:0] len;
		logic go;
	} cmd_t;

endpackage

`default_nettype wire

/* hdl/proto_top.sv */
// Protocol controller top with mailbox, sequencer, SPI and UART blocks
`timescale 1ns/1ps
`default_nettype none

module proto_top (
	input wire clk,
	input wire arst_n_i,
	input wire proto_pkg::mbox_req_t cpu_req_i,
	output logic [proto_pkg::MBOX_DW-1:0] cpu_rdata_o,
	output logic sck_o,
	input wire miso_i,
	output logic mosi_o,
	output logic [3:0] ss_n_o,
	output logic uart_o,
	input wire uart_i,
	output logic int_o
);

	// Controller side of the mailbox
	proto_pkg::mbox_req_t ctrl_req;
	logic [proto_pkg::MBOX_DW-1:0] ctrl_rdata;

	// SPI handshake
	logic spi_start, spi_hold, spi_done;
	logic [7:0] spi_tx_byte, spi_rx_byte;
	logic [1:0] spi_ss;

	// UART handshake
	logic utx_start, utx_done;
	logic [7:0] utx_byte;
	logic urx_valid, urx_take, urx_ovr;
	logic [7:0] urx_byte;

	mailbox_ram u_mbox (
		.clk(clk),
		.a_req_i(cpu_req_i),
		.a_rdata_o(cpu_rdata_o),
		.b_req_i(ctrl_req),
		.b_rdata_o(ctrl_rdata)
	);

	proto_ctrl u_ctrl (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.mb_req_o(ctrl_req),
		.mb_rdata_i(ctrl_rdata),
		.spi_start_o(spi_start),
		.spi_byte_o(spi_tx_byte),
		.spi_ss_o(spi_ss),
		.spi_hold_o(spi_hold),
		.spi_done_i(spi_done),
		.spi_byte_i(spi_rx_byte),
		.utx_start_o(utx_start),
		.utx_byte_o(utx_byte),
		.utx_done_i(utx_done),
		.urx_valid_i(urx_valid),
		.urx_byte_i(urx_byte),
		.urx_take_o(urx_take),
		.urx_ovr_i(urx_ovr),
		.int_o(int_o)
	);

	spi_master u_spi (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.start_i(spi_start),
		.byte_i(spi_tx_byte),
		.ss_sel_i(spi_ss),
		.hold_i(spi_hold),
		.miso_i(miso_i),
		.sck_o(sck_o),
		.mosi_o(mosi_o),
		.ss_n_o(ss_n_o),
		.done_o(spi_done),
		.byte_o(spi_rx_byte)
	);

	uart_tx u_utx (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.start_i(utx_start),
		.byte_i(utx_byte),
		.tx_o(uart_o),
		.done_o(utx_done)
	);

	uart_rx u_urx (
		.clk(clk),
		.arst_n_i(arst_n_i),
		.rx_i(uart_i),
		.take_i(urx_take),
		.valid_o(urx_valid),
		.byte_o(urx_byte),
		.ovr_o(urx_ovr)
	);

endmodule

`default_nettype wire

/* hdl/spi_master.sv */
// Mode-0 SPI master, one byte per start, MSB first, with slave selects
`timescale 1ns/1ps
`default_nettype none

module spi_master (
	input wire clk,
	input wire arst_n_i,
	input wire start_i,
	input wire [7:0] byte_i,
	input wire [1:0] ss_sel_i,
	input wire hold_i,
	input wire miso_i,
	output logic sck_o,
	output logic mosi_o,
	output logic [3:0] ss_n_o,
	output logic done_o,
	output logic [7:0] byte_o
);

	logic busy;
	logic [proto_pkg::SPI_CW-1:0] div_cnt;
	logic [3:0] edge_cnt;
	logic [7:0] tx_sr;
	logic [7:0] rx_sr;
	logic tick, rise, fall;

	// Half-period tick, SCK level picks the edge
	assign tick = busy && (div_cnt == proto_pkg::SPI_LAST);
	assign rise = tick && !sck_o;
	assign fall = tick && sck_o;
	assign byte_o = rx_sr;

	// Shift registers
	always_ff @(posedge clk) begin
		if (start_i && !busy) begin
			tx_sr <= {byte_i[6:0], 1'b0};
		end else if (fall) begin
			tx_sr <= {tx_sr[6:0], 1'b0};
		end
		// Sample on rising SCK
		if (rise) begin
			rx_sr <= {rx_sr[6:0], miso_i};
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= 4'd0;
			sck_o <= 1'b0;
			mosi_o <= 1'b0;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!busy) begin
				div_cnt <= '0;
				edge_cnt <= 4'd0;
				if (start_i) begin
					// First bit set up a half period ahead of SCK
					busy <= 1'b1;
					mosi_o <= byte_i[7];
				end
			end else if (tick) begin
				div_cnt <= '0;
				sck_o <= ~sck_o;
				edge_cnt <= edge_cnt + 4'd1;
				if (fall) begin
					mosi_o <= tx_sr[7];
					if (edge_cnt == 4'd15) begin
						busy <= 1'b0;
						done_o <= 1'b1;
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// Select stays low across the whole command
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ss_n_o <= 4'hF;
		end else begin
			ss_n_o <= hold_i ? ~(4'b0001 << ss_sel_i) : 4'hF;
		end
	end

	// Exactly one slave selected while a byte shifts
	a_one_slave: assert property (@(posedge clk) disable iff (!arst_n_i)
		busy |-> $onehot(~ss_n_o));

endmodule

`default_nettype wire

/* hdl/uart_rx.sv */
// UART 8N1 receiver with mid-bit sampling, holding register and overrun flag
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input wire clk,
	input wire arst_n_i,
	input wire rx_i,
	input wire take_i,
	output logic valid_o,
	output logic [7:0] byte_o,
	output logic ovr_o
);

	logic [1:0] sync;
	logic rx_s;
	logic busy;
	logic [proto_pkg::BAUD_CW-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [7:0] shift;
	logic sample, frame_ok;

	assign rx_s = sync[1];
	assign sample = busy && (baud_cnt == proto_pkg::BAUD_LAST);
	// Stop bit must read high
	assign frame_ok = sample && (bit_cnt == 4'd9) && rx_s;

	// Payload shift and holding register
	always_ff @(posedge clk) begin
		if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
			shift <= {rx_s, shift[7:1]};
		end
		if (frame_ok) begin
			byte_o <= shift;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			sync <= 2'b11;
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= 4'd0;
			valid_o <= 1'b0;
			ovr_o <= 1'b0;
		end else begin
			sync <= {sync[0], rx_i};
			if (!busy) begin
				if (!rx_s) begin
					// Start edge, first sample half a bit later
					busy <= 1'b1;
					baud_cnt <= proto_pkg::BAUD_HALF;
					bit_cnt <= 4'd0;
				end
			end else if (sample) begin
				baud_cnt <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				// Glitch on start, or frame finished
				if ((bit_cnt == 4'd0 && rx_s) || bit_cnt == 4'd9) begin
					busy <= 1'b0;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
			if (frame_ok) begin
				valid_o <= 1'b1;
				// Previous byte never taken, sticky until reset
				if (valid_o && !take_i) begin
					ovr_o <= 1'b1;
				end
			end else if (take_i) begin
				valid_o <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/uart_tx.sv */
// UART 8N1 transmitter, LSB first, one frame per start
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input wire clk,
	input wire arst_n_i,
	input wire start_i,
	input wire [7:0] byte_i,
	output logic tx_o,
	output logic done_o
);

	logic busy;
	logic [proto_pkg::BAUD_CW-1:0] baud_cnt;
	logic [3:0] bit_cnt;
	logic [9:0] frame;
	logic tick;

	assign tick = busy && (baud_cnt == proto_pkg::BAUD_LAST);

	// Stop, data, start; ones fill in behind
	always_ff @(posedge clk) begin
		if (start_i && !busy) begin
			frame <= {1'b1, byte_i, 1'b0};
		end else if (tick) begin
			frame <= {1'b1, frame[9:1]};
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy <= 1'b0;
			baud_cnt <= '0;
			bit_cnt <= 4'd0;
			tx_o <= 1'b1;
			done_o <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!busy) begin
				baud_cnt <= '0;
				bit_cnt <= 4'd0;
				if (start_i) begin
					busy <= 1'b1;
					tx_o <= 1'b0;
				end
			end else if (tick) begin
				baud_cnt <= '0;
				bit_cnt <= bit_cnt + 4'd1;
				// Next bit of the frame
				tx_o <= frame[1];
				if (bit_cnt == 4'd9) begin
					// Stop bit has run its full period
					busy <= 1'b0;
					done_o <= 1'b1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	a_idle_high: assert property (@(posedge clk) disable iff (!arst_n_i)
		!busy |-> tx_o);

endmodule

`default_nettype wire

/* test/proto_tb.sv */
// Testbench for the protocol controller with SPI slave and UART line models
`timescale 1ns/1ps
`default_nettype none

module proto_tb;

	// Cycle limits for interrupt waits
	localparam int CMD_LIMIT = 4000;
	localparam int FRAME_LIMIT = 400;

	logic clk;
	logic arst_n;
	proto_pkg::mbox_req_t cpu_req;
	logic [proto_pkg::MBOX_DW-1:0] cpu_rdata;
	logic sck, mosi, uart_line, uart_rx_line, irq;
	logic miso = 1'b0;
	logic [3:0] ss_n;

	// Scoreboard state
	int seed;
	int errors, checks, tests, mark;
	logic [7:0] cmd_count, urx_count;
	logic [31:0] rx_model [2];

	// SPI capture
	logic sck_q = 1'b0;
	int sck_rises = 0;
	int spi_nbit = 0;
	logic [7:0] spi_bits;
	logic [7:0] mosi_bytes [$];
	logic [3:0] ss_seen [$];

	// UART transmit capture
	logic mon_busy = 1'b0;
	int mon_cnt;
	logic [7:0] mon_data;
	logic [7:0] frame_bytes [$];
	logic frame_stops [$];

	proto_top uut (
		.clk(clk),
		.arst_n_i(arst_n),
		.cpu_req_i(cpu_req),
		.cpu_rdata_o(cpu_rdata),
		.sck_o(sck),
		.miso_i(miso),
		.mosi_o(mosi),
		.ss_n_o(ss_n),
		.uart_o(uart_line),
		.uart_i(uart_rx_line),
		.int_o(irq)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Slave answers with the inverted MOSI bit
	always @(posedge clk) begin
		miso <= ~mosi;
	end

	// MOSI bytes and slave selects, sampled on rising SCK
	always @(posedge clk) begin : spi_mon
		logic [7:0] bits_next;
		sck_q <= sck;
		if (sck && !sck_q) begin
			bits_next = {spi_bits[6:0], mosi};
			spi_bits <= bits_next;
			sck_rises <= sck_rises + 1;
			if (spi_nbit == 7) begin
				mosi_bytes.push_back(bits_next);
				ss_seen.push_back(ss_n);
				spi_nbit <= 0;
			end else begin
				spi_nbit <= spi_nbit + 1;
			end
		end
	end

	// Frame decoder, mid-bit samples counted from the start edge
	always @(posedge clk) begin : uart_mon
		int k;
		if (!mon_busy) begin
			if (!uart_line) begin
				mon_busy <= 1'b1;
				mon_cnt <= 2;
			end
		end else begin
			mon_cnt <= mon_cnt + 1;
			if (mon_cnt % proto_pkg::BAUD_DIV == proto_pkg::BAUD_DIV / 2) begin
				k = mon_cnt / proto_pkg::BAUD_DIV;
				if (k >= 1 && k <= 8) begin
					mon_data <= {uart_line, mon_data[7:1]};
				end
				if (k == 9) begin
					frame_bytes.push_back(mon_data);
					frame_stops.push_back(uart_line);
					mon_busy <= 1'b0;
				end
			end
		end
	end

	// Expected MISO reply for one MOSI byte
	function automatic logic [7:0] spi_ref(input logic [7:0] b);
		return ~b;
	endfunction

	function automatic bit cmd_error(input logic [3:0] op, input logic [3:0] len);
		if (op == proto_pkg::OP_SPI_XFER || op == proto_pkg::OP_UART_SEND) begin
			return (len == 4'd0) || (len > 4'd8);
		end
		return op != proto_pkg::OP_NOP;
	endfunction

	function automatic logic [31:0] status_ref(input logic [7:0] cnt, input logic [3:0] op,
			input bit err, input bit ovr);
		logic [31:0] s;
		s = '0;
		s[7:0] = cnt;
		s[proto_pkg::STAT_OP_LSB +: 4] = op;
		s[proto_pkg::STAT_ERR_BIT] = err;
		s[proto_pkg::STAT_OVR_BIT] = ovr;
		return s;
	endfunction

	task automatic check_word(input logic [proto_pkg::MBOX_DW-1:0] got,
			input logic [proto_pkg::MBOX_DW-1:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_ss(input logic [3:0] got, input logic [3:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic mb_write(input logic [proto_pkg::MBOX_AW-1:0] waddr, input logic [31:0] wdat);
		@(posedge clk);
		cpu_req <= '{addr: waddr, be: 4'hF, wdata: wdat};
		@(posedge clk);
		cpu_req.be <= 4'h0;
	endtask

	// Address held two edges, data valid one cycle after the RAM samples it
	task automatic mb_read(input logic [proto_pkg::MBOX_AW-1:0] raddr, output logic [31:0] rdat);
		@(posedge clk);
		cpu_req <= '{addr: raddr, be: 4'h0, wdata: '0};
		@(posedge clk);
		@(posedge clk);
		rdat = cpu_rdata;
	endtask

	task automatic wait_int(input int limit, input string what);
		bit seen;
		seen = 1'b0;
		for (int n = 0; n < limit && !seen; n++) begin
			@(posedge clk);
			seen = irq;
		end
		if (!seen) begin
			errors++;
			$display("timeout: no interrupt for %s within %0d cycles", what, limit);
		end else begin
			@(posedge clk);
			if (irq) begin
				errors++;
				$display("interrupt for %s stayed high longer than one cycle", what);
			end
		end
	endtask

	// One 8N1 frame on the receive pin
	task automatic send_uart(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
			uart_rx_line <= frame[i];
			repeat (proto_pkg::BAUD_DIV - 1) @(posedge clk);
		end
	endtask

	task automatic recv_byte(input logic [7:0] b);
		logic [31:0] word;
		fork
			send_uart(b);
			wait_int(FRAME_LIMIT, "UART receive");
		join
		urx_count = urx_count + 8'd1;
		mb_read(proto_pkg::ADDR_URX, word);
		check_word(word, {16'h0, urx_count, b}, "UART receive word");
	endtask

	task automatic run_command(input logic [3:0] op, input logic [1:0] ss, input logic [3:0] len);
		logic [7:0] tx [8];
		logic [31:0] cmd, word;
		logic [3:0] ss_exp;
		bit err;
		int sck_base;
		for (int i = 0; i < 8; i++) begin
			tx[i] = 8'($random(seed));
		end
		err = cmd_error(op, len);
		// Selected line low, the other three high
		ss_exp = 4'hF;
		ss_exp[ss] = 1'b0;
		mb_write(proto_pkg::ADDR_TX0, {tx[3], tx[2], tx[1], tx[0]});
		mb_write(proto_pkg::ADDR_TX1, {tx[7], tx[6], tx[5], tx[4]});
		mosi_bytes.delete();
		ss_seen.delete();
		frame_bytes.delete();
		frame_stops.delete();
		sck_base = sck_rises;
		cmd = {1'b1, 19'h0, len, 2'b00, ss, op};
		mb_write(proto_pkg::ADDR_CMD, cmd);
		wait_int(CMD_LIMIT, "command completion");
		cmd_count = cmd_count + 8'd1;
		mb_read(proto_pkg::ADDR_CMD, word);
		check_word(word, {1'b0, cmd[30:0]}, "command word after go");
		mb_read(proto_pkg::ADDR_STAT, word);
		check_word(word, status_ref(cmd_count, op, err, 1'b0), "status word");
		if (!err && op == proto_pkg::OP_SPI_XFER) begin
			check_word(32'(mosi_bytes.size()), 32'(len), "SPI byte count");
			for (int i = 0; i < len && i < mosi_bytes.size(); i++) begin
				check_byte(mosi_bytes[i], tx[i], "MOSI byte");
				check_ss(ss_seen[i], ss_exp, "slave selects during byte");
				rx_model[i / 4][8 * (i % 4) +: 8] = spi_ref(tx[i]);
			end
		end else begin
			check_word(32'(sck_rises - sck_base), 32'h0, "SCK edges outside SPI");
		end
		// RX words keep bytes beyond the last transfer
		mb_read(proto_pkg::ADDR_RX0, word);
		check_word(word, rx_model[0], "RX0 word");
		mb_read(proto_pkg::ADDR_RX1, word);
		check_word(word, rx_model[1], "RX1 word");
		if (!err && op == proto_pkg::OP_UART_SEND) begin
			check_word(32'(frame_bytes.size()), 32'(len), "UART frame count");
			for (int i = 0; i < len && i < frame_bytes.size(); i++) begin
				check_byte(frame_bytes[i], tx[i], "UART frame byte");
				check_byte({7'h0, frame_stops[i]}, 8'h01, "UART stop bit");
			end
		end else begin
			check_word(32'(frame_bytes.size()), 32'h0, "UART frames outside send");
		end
		check_ss(ss_n, 4'hF, "slave selects after command");
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == mark) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			$display("test %0d %s: %0d errors", tests, name, errors - mark);
		end
		mark = errors;
	endtask

	initial begin
		logic [31:0] word;
		int kind;
		logic [3:0] op, len;
		cpu_req = '0;
		uart_rx_line = 1'b1;
		arst_n = 1'b0;
		seed = 32'hff54_5cf9;
		errors = 0;
		checks = 0;
		tests = 0;
		mark = 0;
		cmd_count = 8'd0;
		urx_count = 8'd0;
		rx_model[0] = '0;
		rx_model[1] = '0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// Idle pins and a cleared mailbox
		check_ss(ss_n, 4'hF, "slave selects out of reset");
		check_byte({5'h0, sck, mosi, irq}, 8'h00, "SCK, MOSI and interrupt out of reset");
		check_byte({7'h0, uart_line}, 8'h01, "UART line out of reset");
		for (int a = 0; a < 2**proto_pkg::MBOX_AW; a++) begin
			mb_read(proto_pkg::MBOX_AW'(a), word);
			check_word(word, 32'h0, $sformatf("mailbox word %0d out of reset", a));
		end
		end_test("reset state");

		for (int i = 0; i < 3; i++) begin
			run_command(proto_pkg::OP_SPI_XFER, 2'($random(seed)),
				4'(1 + {$random(seed)} % 8));
		end
		end_test("SPI transfer");

		for (int i = 0; i < 2; i++) begin
			run_command(proto_pkg::OP_UART_SEND, 2'd0, 4'(1 + {$random(seed)} % 8));
		end
		end_test("UART send");

		recv_byte(8'($random(seed)));
		recv_byte(8'($random(seed)));
		end_test("UART receive");

		run_command(4'h9, 2'd1, 4'd3);
		run_command(proto_pkg::OP_SPI_XFER, 2'd2, 4'd0);
		end_test("bad command");

		// Seeded mix of good transfers, receives and bad commands
		for (int i = 0; i < 12; i++) begin
			kind = {$random(seed)} % 4;
			case (kind)
				0: run_command(proto_pkg::OP_SPI_XFER, 2'($random(seed)),
					4'(1 + {$random(seed)} % 8));
				1: run_command(proto_pkg::OP_UART_SEND, 2'd0, 4'(1 + {$random(seed)} % 8));
				2: recv_byte(8'($random(seed)));
				default: begin
					if ({$random(seed)} % 2 == 0) begin
						op = 4'(3 + {$random(seed)} % 13);
						len = 4'($random(seed));
					end else begin
						op = ({$random(seed)} % 2 == 0) ? 4'h1 : 4'h2;
						len = ({$random(seed)} % 2 == 0) ? 4'd0 : 4'(9 + {$random(seed)} % 7);
					end
					run_command(op, 2'($random(seed)), len);
				end
			endcase
		end
		end_test("random mix");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
hdl/proto_pkg.sv
hdl/mailbox_ram.sv
hdl/spi_master.sv
hdl/uart_tx.sv
hdl/uart_rx.sv
hdl/proto_ctrl.sv
hdl/proto_top.sv
test/proto_tb.sv
